// ==== Makefile ====
# Verilator build and run of the csr unit testbench
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== csr_regfile.sv ====
// machine csrs, read mux, read-modify-write, trap entry and mret updates, registered trap outputs
`timescale 1ns/1ns

module csr_regfile #(
    parameter logic [31:0] TRAP_ADDRESS = 32'h0 // mtvec reset value
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  csr_unit_pkg::csr_cmd_t   i_cmd,
    input  csr_unit_pkg::exc_req_t   i_exc,
    input  logic                     i_ext_irq,
    input  logic                     i_sw_irq,
    input  logic                     i_timer_irq,
    input  logic [63:0]              i_mtime,
    input  logic [63:0]              i_mcycle,
    input  logic [31:0]              i_pc,
    input  logic                     i_ce,
    input  logic                     i_change_pc,
    input  csr_unit_pkg::trap_req_t  i_trap,
    output csr_unit_pkg::irq_state_t o_irq,
    output csr_unit_pkg::csr_word_u  o_mtvec,
    output csr_unit_pkg::cnt_wr_t    o_cnt_wr,
    output logic [31:0]              o_csr_out,
    output logic [31:0]              o_trap_address,
    output logic [31:0]              o_return_address,
    output logic                     o_go_to_trap_q,
    output logic                     o_return_from_trap_q
);
    import csr_unit_pkg::*;

    localparam logic [31:0] MISA_VALUE = 32'h4000_0100; // mxl = 32 bit, i extension

    csr_addr_e   addr;
    csr_op_e     op;
    csr_word_u   rd_word;      // current contents of the addressed csr
    csr_word_u   wr_word;      // value after the funct3 rule
    logic [31:0] src;          // rs1 or zimm
    logic        csr_en;
    logic        trap_en;      // first edge of a trap request
    logic        ret_en;
    logic        mstatus_mie;
    logic        mstatus_mpie;
    logic        mie_meie;
    logic        mie_msie;
    logic        mie_mtie;
    csr_word_u   mtvec_q;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic        mcause_int;
    logic [3:0]  mcause_code;
    logic        mip_meip;     // interrupt lines, one clock late
    logic        mip_msip;
    logic        mip_mtip;

    assign addr    = csr_addr_e'(i_cmd.index);
    assign op      = csr_op_e'(i_cmd.funct3);
    assign csr_en  = i_cmd.is_system && (i_cmd.funct3 != 3'd0) && i_ce && !i_change_pc;
    assign trap_en = i_ce && i_trap.take && !o_go_to_trap_q;
    assign ret_en  = i_ce && i_exc.mret && !i_trap.take; // a trap beats mret
    assign src     = i_cmd.funct3[2] ? {27'd0, i_cmd.imm} : i_cmd.rs1;

    always_comb begin
        rd_word.raw = 32'd0; // unmapped addresses read zero
        case (addr)
            CSR_MSTATUS: begin
                rd_word.raw[MSTATUS_MIE_BIT]  = mstatus_mie;
                rd_word.raw[MSTATUS_MPIE_BIT] = mstatus_mpie;
                rd_word.raw[12:11]            = 2'b11; // mpp, machine mode only
            end
            CSR_MISA:     rd_word.raw = MISA_VALUE;
            CSR_MIE: begin
                rd_word.raw[IRQ_SW_BIT]    = mie_msie;
                rd_word.raw[IRQ_TIMER_BIT] = mie_mtie;
                rd_word.raw[IRQ_EXT_BIT]   = mie_meie;
            end
            CSR_MTVEC:    rd_word.raw = mtvec_q.raw;
            CSR_MSCRATCH: rd_word.raw = mscratch;
            CSR_MEPC:     rd_word.raw = mepc;
            CSR_MCAUSE: begin
                rd_word.mcause.intr = mcause_int;
                rd_word.mcause.code = mcause_code;
            end
            CSR_MIP: begin
                rd_word.raw[IRQ_SW_BIT]    = mip_msip;
                rd_word.raw[IRQ_TIMER_BIT] = mip_mtip;
                rd_word.raw[IRQ_EXT_BIT]   = mip_meip;
            end
            CSR_MCYCLE:   rd_word.raw = i_mcycle[31:0];
            CSR_MCYCLEH:  rd_word.raw = i_mcycle[63:32];
            CSR_TIME:     rd_word.raw = i_mtime[31:0];
            CSR_TIMEH:    rd_word.raw = i_mtime[63:32];
            default:      rd_word.raw = 32'd0;
        endcase
    end

    always_comb begin
        case (op)
            CSRRW, CSRRWI: wr_word.raw = src;
            CSRRS, CSRRSI: wr_word.raw = rd_word.raw | src;
            CSRRC, CSRRCI: wr_word.raw = rd_word.raw & ~src;
            default:       wr_word.raw = rd_word.raw; // funct3 0 never enables a write
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mie_msie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mtvec_q.raw  <= TRAP_ADDRESS;
            mscratch     <= 32'd0;
            mepc         <= 32'd0;
            mcause_int   <= 1'b0;
            mcause_code  <= 4'd0;
            mip_meip     <= 1'b0;
            mip_msip     <= 1'b0;
            mip_mtip     <= 1'b0;
        end else begin
            if (csr_en && addr == CSR_MSTATUS) begin // software write wins
                mstatus_mie  <= wr_word.raw[MSTATUS_MIE_BIT];
                mstatus_mpie <= wr_word.raw[MSTATUS_MPIE_BIT];
            end else if (trap_en) begin
                mstatus_mie  <= 1'b0;        // handler runs with interrupts off
                mstatus_mpie <= mstatus_mie;
            end else if (ret_en) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
            if (csr_en && addr == CSR_MIE) begin
                mie_msie <= wr_word.raw[IRQ_SW_BIT];
                mie_mtie <= wr_word.raw[IRQ_TIMER_BIT];
                mie_meie <= wr_word.raw[IRQ_EXT_BIT];
            end
            if (csr_en && addr == CSR_MTVEC)
                mtvec_q <= wr_word;
            if (csr_en && addr == CSR_MSCRATCH)
                mscratch <= wr_word.raw;
            if (trap_en)
                mepc <= i_pc;                          // pc of the trapped instruction
            else if (csr_en && addr == CSR_MEPC)
                mepc <= {wr_word.raw[31:2], 2'b00};
            if (trap_en) begin
                mcause_int  <= i_trap.is_interrupt;
                mcause_code <= i_trap.cause;
            end else if (csr_en && addr == CSR_MCAUSE) begin
                mcause_int  <= wr_word.raw[MCAUSE_INT_BIT];
                mcause_code <= wr_word.mcause.code;
            end
            mip_meip <= i_ext_irq;
            mip_msip <= i_sw_irq;
            mip_mtip <= i_timer_irq;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_csr_out            <= 32'd0;
            o_trap_address       <= 32'd0;
            o_return_address     <= 32'd0;
            o_go_to_trap_q       <= 1'b0;
            o_return_from_trap_q <= 1'b0;
        end else if (i_ce) begin // stall holds everything
            o_csr_out            <= rd_word.raw;    // old value, new one lands at the same edge
            o_trap_address       <= i_trap.target;
            o_return_address     <= mepc;
            o_go_to_trap_q       <= i_trap.take;
            o_return_from_trap_q <= i_exc.mret && !i_trap.take;
        end
    end

    always_comb begin
        o_irq.mstatus_mie = mstatus_mie;
        o_irq.meie        = mie_meie;
        o_irq.msie        = mie_msie;
        o_irq.mtie        = mie_mtie;
        o_irq.meip        = mip_meip;
        o_irq.msip        = mip_msip;
        o_irq.mtip        = mip_mtip;
        o_cnt_wr.wr_lo    = csr_en && (addr == CSR_MCYCLE);
        o_cnt_wr.wr_hi    = csr_en && (addr == CSR_MCYCLEH);
        o_cnt_wr.data     = wr_word.raw;
    end

    assign o_mtvec = mtvec_q;
endmodule

// ==== csr_timer.sv ====
// mtime prescaler and counter, mtimecmp compare, free-running mcycle counter with csr write path
`timescale 1ns/1ns

module csr_timer #(
    parameter int MTIME_TICK_CYCLES = 100000 // clocks per mtime tick
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  csr_unit_pkg::cnt_wr_t i_cnt_wr,
    input  logic                  i_mtime_wr,
    input  logic [63:0]           i_mtime_din,
    input  logic                  i_mtimecmp_wr,
    input  logic [63:0]           i_mtimecmp_din,
    output logic [63:0]           o_mtime,
    output logic [63:0]           o_mcycle,
    output logic                  o_timer_irq
);
    localparam int                 PRESC_W    = $clog2(MTIME_TICK_CYCLES + 1);
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(MTIME_TICK_CYCLES - 1);

    logic [PRESC_W-1:0] presc;    // clocks since last tick
    logic [63:0]        mtime;
    logic [63:0]        mtimecmp;
    logic [63:0]        mcycle;
    logic               tick;

    assign tick = (presc == PRESC_LAST); // last clock of the period

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            presc <= '0;
            mtime <= '0;
        end else if (i_mtime_wr) begin
            presc <= '0;          // new value restarts the period
            mtime <= i_mtime_din;
        end else if (tick) begin
            presc <= '0;
            mtime <= mtime + 64'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            mtimecmp <= '1; // far future, no interrupt out of reset
        else if (i_mtimecmp_wr)
            mtimecmp <= i_mtimecmp_din;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            mcycle <= '0;
        else if (i_cnt_wr.wr_lo)
            mcycle[31:0] <= i_cnt_wr.data;  // csr write wins over the count
        else if (i_cnt_wr.wr_hi)
            mcycle[63:32] <= i_cnt_wr.data;
        else
            mcycle <= mcycle + 64'd1;
    end

    assign o_mtime     = mtime;
    assign o_mcycle    = mcycle;
    assign o_timer_irq = (mtime >= mtimecmp); // unsigned compare, level held until mtimecmp moves
endmodule

// ==== csr_trap_arbiter.sv ====
// interrupt masking, trap cause priority and trap target address
`timescale 1ns/1ns

module csr_trap_arbiter (
    input  csr_unit_pkg::irq_state_t i_irq,
    input  csr_unit_pkg::exc_req_t   i_exc,
    input  csr_unit_pkg::csr_word_u  i_mtvec,
    output csr_unit_pkg::trap_req_t  o_trap
);
    import csr_unit_pkg::*;

    localparam logic [1:0] MODE_VECTORED = 2'b01;

    logic        ext_pend;   // enabled and pending
    logic        sw_pend;
    logic        tmr_pend;
    logic        is_irq;
    logic        is_exc;
    logic [3:0]  cause;
    logic [31:0] base_addr;
    logic [31:0] vec_offset;

    assign ext_pend = i_irq.mstatus_mie & i_irq.meie & i_irq.meip;
    assign sw_pend  = i_irq.mstatus_mie & i_irq.msie & i_irq.msip;
    assign tmr_pend = i_irq.mstatus_mie & i_irq.mtie & i_irq.mtip;

    assign is_irq = ext_pend | sw_pend | tmr_pend;
    assign is_exc = i_exc.illegal | i_exc.ecall | i_exc.ebreak;

    // interrupts first, then synchronous exceptions
    always_comb begin
        cause = 4'd0;
        if (ext_pend)
            cause = CAUSE_EXT_IRQ;
        else if (sw_pend)
            cause = CAUSE_SW_IRQ;
        else if (tmr_pend)
            cause = CAUSE_TIMER_IRQ;
        else if (i_exc.illegal)
            cause = CAUSE_ILLEGAL;
        else if (i_exc.ecall)
            cause = CAUSE_ECALL;
        else if (i_exc.ebreak)
            cause = CAUSE_EBREAK;
    end

    assign base_addr  = {i_mtvec.mtvec.base, 2'b00};
    assign vec_offset = (i_mtvec.mtvec.mode == MODE_VECTORED && is_irq) ?
                        {26'd0, cause, 2'b00} : 32'd0; // 4 * cause, interrupts only

    always_comb begin
        o_trap.take         = is_irq | is_exc;
        o_trap.is_interrupt = is_irq;
        o_trap.cause        = cause;
        o_trap.target       = base_addr + vec_offset;
    end
endmodule

// ==== csr_unit.f ====
csr_unit_pkg.sv
csr_timer.sv
csr_trap_arbiter.sv
csr_regfile.sv
csr_unit.sv
csr_unit_checker.sv
csr_unit_tb.sv

// ==== csr_unit.sv ====
// top level of the csr unit, timer, trap arbiter and register file
`timescale 1ns/1ns

module csr_unit #(
    parameter int          MTIME_TICK_CYCLES = 100000, // 1 ms at 100 MHz
    parameter logic [31:0] TRAP_ADDRESS      = 32'h0
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  csr_unit_pkg::csr_cmd_t i_cmd,
    input  csr_unit_pkg::exc_req_t i_exc,
    input  logic                   i_ext_irq,
    input  logic                   i_sw_irq,
    input  logic                   i_mtime_wr,
    input  logic [63:0]            i_mtime_din,
    input  logic                   i_mtimecmp_wr,
    input  logic [63:0]            i_mtimecmp_din,
    input  logic [31:0]            i_pc,
    input  logic                   i_ce,
    input  logic                   i_change_pc,
    output logic [31:0]            o_csr_out,
    output logic [31:0]            o_trap_address,
    output logic [31:0]            o_return_address,
    output logic                   o_go_to_trap_q,
    output logic                   o_return_from_trap_q
);
    import csr_unit_pkg::*;

    irq_state_t  irq;       // enables and pending bits to the arbiter
    csr_word_u   mtvec;
    cnt_wr_t     cnt_wr;    // mcycle csr writes
    trap_req_t   trap;
    logic [63:0] mtime;
    logic [63:0] mcycle;
    logic        timer_irq;

    csr_timer #(.MTIME_TICK_CYCLES(MTIME_TICK_CYCLES)) timer_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cnt_wr(cnt_wr),
        .i_mtime_wr(i_mtime_wr), .i_mtime_din(i_mtime_din),
        .i_mtimecmp_wr(i_mtimecmp_wr), .i_mtimecmp_din(i_mtimecmp_din),
        .o_mtime(mtime), .o_mcycle(mcycle), .o_timer_irq(timer_irq)
    );

    csr_trap_arbiter arbiter_inst (.i_irq(irq), .i_exc(i_exc), .i_mtvec(mtvec), .o_trap(trap));

    csr_regfile #(.TRAP_ADDRESS(TRAP_ADDRESS)) regfile_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_cmd(i_cmd), .i_exc(i_exc),
        .i_ext_irq(i_ext_irq), .i_sw_irq(i_sw_irq), .i_timer_irq(timer_irq),
        .i_mtime(mtime), .i_mcycle(mcycle), .i_pc(i_pc), .i_ce(i_ce),
        .i_change_pc(i_change_pc), .i_trap(trap), .o_irq(irq), .o_mtvec(mtvec),
        .o_cnt_wr(cnt_wr), .o_csr_out(o_csr_out), .o_trap_address(o_trap_address),
        .o_return_address(o_return_address), .o_go_to_trap_q(o_go_to_trap_q),
        .o_return_from_trap_q(o_return_from_trap_q)
    );
endmodule

// ==== csr_unit_checker.sv ====
// bound assertions on the trap outputs of the csr unit
`timescale 1ns/1ns

module csr_unit_checker (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_ce,
    input logic        i_go_to_trap_q,
    input logic        i_return_from_trap_q,
    input logic [31:0] i_trap_address
);
    int unsigned fail_count = 0; // number of failed assertions

    trap_ret_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_go_to_trap_q && i_return_from_trap_q)) // trap beats mret in the regfile
    else begin
        fail_count++;
        $error("o_go_to_trap_q and o_return_from_trap_q high in the same cycle");
    end

    stall_holds_low: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_ce && !i_go_to_trap_q) |=> !i_go_to_trap_q) // stall freezes the registered outputs
    else begin
        fail_count++;
        $error("o_go_to_trap_q rose while i_ce was low");
    end

    target_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_go_to_trap_q |-> (i_trap_address[1:0] == 2'b00)) // handler address is a word
    else begin
        fail_count++;
        $error("trap address %h is not word aligned", i_trap_address);
    end
endmodule

// ==== csr_unit_pkg.sv ====
// csr addresses, operation codes, trap cause codes, bit positions, csr word union and port structs
package csr_unit_pkg;

    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300, // status, mie/mpie/mpp
        CSR_MISA     = 12'h301, // isa description, read only
        CSR_MIE      = 12'h304, // interrupt enables
        CSR_MTVEC    = 12'h305, // trap vector base and mode
        CSR_MSCRATCH = 12'h340, // scratch word for the handler
        CSR_MEPC     = 12'h341, // pc of the trapped instruction
        CSR_MCAUSE   = 12'h342, // trap cause
        CSR_MIP      = 12'h344, // pending interrupts, read only
        CSR_MCYCLE   = 12'hB00, // cycle counter low half
        CSR_MCYCLEH  = 12'hB80, // cycle counter high half
        CSR_TIME     = 12'hC01, // mtime low half, read only
        CSR_TIMEH    = 12'hC81  // mtime high half, read only
    } csr_addr_e;

    typedef enum logic [2:0] {
        CSRRW  = 3'b001, // write rs1
        CSRRS  = 3'b010, // set bits from rs1
        CSRRC  = 3'b011, // clear bits from rs1
        CSRRWI = 3'b101, // write zimm
        CSRRSI = 3'b110, // set bits from zimm
        CSRRCI = 3'b111  // clear bits from zimm
    } csr_op_e;

    localparam logic [3:0] CAUSE_SW_IRQ    = 4'd3;  // with mcause bit 31 set
    localparam logic [3:0] CAUSE_TIMER_IRQ = 4'd7;
    localparam logic [3:0] CAUSE_EXT_IRQ   = 4'd11;
    localparam logic [3:0] CAUSE_ILLEGAL   = 4'd2;  // exceptions, bit 31 clear
    localparam logic [3:0] CAUSE_EBREAK    = 4'd3;
    localparam logic [3:0] CAUSE_ECALL     = 4'd11;

    localparam int IRQ_SW_BIT       = 3;  // same positions in mie and mip
    localparam int IRQ_TIMER_BIT    = 7;
    localparam int IRQ_EXT_BIT      = 11;
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MCAUSE_INT_BIT   = 31;

    // one csr data word, seen as raw bits or through the mtvec / mcause layouts
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29:0] base; // word-aligned vector base
            logic [1:0]  mode; // 0 direct, 1 vectored
        } mtvec;
        struct packed {
            logic        intr;   // interrupt flag
            logic [26:0] unused;
            logic [3:0]  code;   // cause code
        } mcause;
    } csr_word_u;

    typedef struct packed {
        logic        is_system; // system opcode
        logic [2:0]  funct3;    // csr operation, zero for non-csr
        logic [11:0] index;     // csr address
        logic [4:0]  imm;       // zimm, zero-extended when used
        logic [31:0] rs1;       // source register value
    } csr_cmd_t;

    typedef struct packed {
        logic illegal;
        logic ecall;
        logic ebreak;
        logic mret;
    } exc_req_t;

    typedef struct packed {
        logic mstatus_mie; // global enable
        logic meie;
        logic msie;
        logic mtie;
        logic meip;
        logic msip;
        logic mtip;
    } irq_state_t;

    typedef struct packed {
        logic        take;         // a trap is requested this cycle
        logic        is_interrupt;
        logic [3:0]  cause;
        logic [31:0] target;       // handler address
    } trap_req_t;

    typedef struct packed {
        logic        wr_lo; // csr write of mcycle
        logic        wr_hi; // csr write of mcycleh
        logic [31:0] data;
    } cnt_wr_t;

endpackage

// ==== csr_unit_tb.sv ====
// testbench for the csr unit: clock, reset, stimulus table with expected values, timer and mcycle
`timescale 1ns/1ns

module csr_unit_tb;
    import csr_unit_pkg::*;

    localparam logic [31:0] TVEC      = 32'h100;        // mtvec reset value
    localparam logic [31:0] PC        = 32'h0000_0240;  // pc seen by every trap
    localparam logic [31:0] MISA      = 32'h4000_0100;  // base field 01, bit 8 for rv32i
    localparam logic [31:0] MPP_M     = 32'h0000_1800;  // mstatus.mpp = 3
    localparam exc_req_t    EXC_NONE  = 4'b0000;
    localparam exc_req_t    EXC_ECALL = 4'b0100;        // illegal, ecall, ebreak, mret
    localparam exc_req_t    EXC_MRET  = 4'b0001;
    localparam int          TIMEOUT   = 200;            // clocks to wait for the timer trap

    typedef struct packed {
        csr_cmd_t    cmd;
        exc_req_t    exc;
        logic        ext_irq;
        logic        sw_irq;
        logic        ce;
        logic        chk_out;        // compare o_csr_out
        logic [31:0] exp_out;
        logic        exp_trap;
        logic [31:0] exp_trap_addr;
        logic        exp_ret;
        logic [31:0] exp_ret_addr;
    } step_t;

    logic        clk;
    logic        rst_n;
    csr_cmd_t    cmd;
    exc_req_t    exc;
    logic        ext_irq;
    logic        sw_irq;
    logic        mtime_wr;
    logic [63:0] mtime_din;
    logic        mtimecmp_wr;
    logic [63:0] mtimecmp_din;
    logic        ce;
    logic [31:0] csr_out;
    logic [31:0] trap_address;
    logic [31:0] return_address;
    logic        go_to_trap;
    logic        return_from_trap;
    step_t       steps[$];
    step_t       idle;           // no command, no request, clock enabled

    csr_unit #(.MTIME_TICK_CYCLES(10), .TRAP_ADDRESS(TVEC)) csr_unit_inst (
        .i_clk(clk), .i_rst_n(rst_n), .i_cmd(cmd), .i_exc(exc), .i_ext_irq(ext_irq),
        .i_sw_irq(sw_irq), .i_mtime_wr(mtime_wr), .i_mtime_din(mtime_din),
        .i_mtimecmp_wr(mtimecmp_wr), .i_mtimecmp_din(mtimecmp_din), .i_pc(PC), .i_ce(ce),
        .i_change_pc(1'b0), .o_csr_out(csr_out), .o_trap_address(trap_address),
        .o_return_address(return_address), .o_go_to_trap_q(go_to_trap),
        .o_return_from_trap_q(return_from_trap)
    );

    bind csr_unit csr_unit_checker checker_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ce(i_ce), .i_go_to_trap_q(o_go_to_trap_q),
        .i_return_from_trap_q(o_return_from_trap_q), .i_trap_address(o_trap_address)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // expected csr value after each funct3 rule
    function automatic logic [31:0] rmw_model(csr_op_e op, logic [31:0] old, logic [31:0] rs1,
                                              logic [4:0] imm);
        logic [31:0] zimm;
        zimm = {27'd0, imm};
        case (op)
            CSRRW:   return rs1;
            CSRRS:   return old | rs1;
            CSRRC:   return old & ~rs1;
            CSRRWI:  return zimm;
            CSRRSI:  return old | zimm;
            default: return old & ~zimm;
        endcase
    endfunction

    function automatic step_t csr_step(csr_op_e op, logic [11:0] index, logic [31:0] rs1,
                                       logic [4:0] imm, logic chk, logic [31:0] exp_out);
        step_t s;
        s               = '0;
        s.ce            = 1'b1;
        s.cmd.is_system = 1'b1;
        s.cmd.funct3    = op;
        s.cmd.index     = index;
        s.cmd.imm       = imm;
        s.cmd.rs1       = rs1;
        s.chk_out       = chk;
        s.exp_out       = exp_out; // old value of the csr
        return s;
    endfunction

    function automatic step_t event_step(exc_req_t req, logic irqs, logic en, logic trap,
                                         logic [31:0] trap_addr, logic ret);
        step_t s;
        s               = '0;
        s.exc           = req;
        s.ext_irq       = irqs;    // external and software raised together
        s.sw_irq        = irqs;
        s.ce            = en;
        s.exp_trap      = trap;
        s.exp_trap_addr = trap_addr;
        s.exp_ret       = ret;
        s.exp_ret_addr  = PC;      // mepc always holds the trapped pc here
        return s;
    endfunction

    task automatic drive_step(step_t s);
        cmd     <= s.cmd;
        exc     <= s.exc;
        ext_irq <= s.ext_irq;
        sw_irq  <= s.sw_irq;
        ce      <= s.ce;
    endtask

    task automatic stop_on_error(string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_step(int idx, step_t s);
        assert (!s.chk_out || csr_out == s.exp_out) else
            stop_on_error($sformatf("step %0d o_csr_out %h, expected %h", idx, csr_out,
                                    s.exp_out));
        assert (go_to_trap == s.exp_trap) else
            stop_on_error($sformatf("step %0d o_go_to_trap_q %b, expected %b", idx,
                                    go_to_trap, s.exp_trap));
        assert (!s.exp_trap || trap_address == s.exp_trap_addr) else
            stop_on_error($sformatf("step %0d o_trap_address %h, expected %h", idx,
                                    trap_address, s.exp_trap_addr));
        assert (return_from_trap == s.exp_ret) else
            stop_on_error($sformatf("step %0d o_return_from_trap_q %b, expected %b", idx,
                                    return_from_trap, s.exp_ret));
        assert (!s.exp_ret || return_address == s.exp_ret_addr) else
            stop_on_error($sformatf("step %0d o_return_address %h, expected %h", idx,
                                    return_address, s.exp_ret_addr));
    endtask

    // read-set with zero, value shows one clock after the access
    task automatic csr_read(csr_addr_e index, output logic [31:0] data);
        @(posedge clk);
        drive_step(csr_step(CSRRS, index, 32'd0, 5'd0, 1'b0, 32'd0));
        @(posedge clk);
        drive_step(idle);
        @(negedge clk);
        data = csr_out;
    endtask

    initial begin
        logic [31:0] scratch;
        logic [31:0] rs1;
        logic [4:0]  imm;
        logic [31:0] rd_a;
        logic [31:0] rd_b;
        logic        seen;
        int          n;
        int          cnt;
        csr_op_e     op;
        rst_n        = 1'b0;
        cmd          = '0;
        exc          = '0;
        ext_irq      = 1'b0;
        sw_irq       = 1'b0;
        mtime_wr     = 1'b0;
        mtime_din    = '0;
        mtimecmp_wr  = 1'b0;
        mtimecmp_din = '0;
        ce           = 1'b1;
        scratch      = 32'd0;
        void'($urandom(54));
        idle = event_step(EXC_NONE, 1'b0, 1'b1, 1'b0, 32'd0, 1'b0);

        steps.push_back(csr_step(CSRRS, CSR_MTVEC, 32'd0, 5'd0, 1'b1, TVEC));
        op = op.first();
        repeat (6) begin // all six operations on mscratch
            rs1 = $urandom;
            imm = 5'($urandom);
            steps.push_back(csr_step(op, CSR_MSCRATCH, rs1, imm, 1'b1, scratch));
            scratch = rmw_model(op, scratch, rs1, imm);
            op = op.next();
        end
        steps.push_back(csr_step(CSRRS, CSR_MSCRATCH, 32'd0, 5'd0, 1'b1, scratch));
        steps.push_back(csr_step(CSRRW, CSR_MEPC, 32'h1234_5677, 5'd0, 1'b0, 32'd0));
        steps.push_back(csr_step(CSRRS, CSR_MEPC, 32'd0, 5'd0, 1'b1, 32'h1234_5674));
        steps.push_back(csr_step(CSRRS, CSR_MISA, 32'd0, 5'd0, 1'b1, MISA));
        steps.push_back(csr_step(CSRRS, 12'h7C0, $urandom, 5'd0, 1'b1, 32'd0)); // unmapped
        steps.push_back(csr_step(CSRRSI, CSR_MSTATUS, 32'd0, 5'd8, 1'b1, MPP_M)); // mie on
        steps.push_back(event_step(EXC_ECALL, 1'b0, 1'b0, 1'b0, 32'd0, 1'b0)); // stalled
        steps.push_back(event_step(EXC_ECALL, 1'b0, 1'b1, 1'b1, TVEC, 1'b0));
        steps.push_back(csr_step(CSRRS, CSR_MCAUSE, 32'd0, 5'd0, 1'b1, 32'(CAUSE_ECALL)));
        steps.push_back(csr_step(CSRRS, CSR_MEPC, 32'd0, 5'd0, 1'b1, PC));
        steps.push_back(csr_step(CSRRS, CSR_MSTATUS, 32'd0, 5'd0, 1'b1, MPP_M | 32'h80));
        steps.push_back(event_step(EXC_MRET, 1'b0, 1'b1, 1'b0, 32'd0, 1'b1));
        steps.push_back(csr_step(CSRRS, CSR_MSTATUS, 32'd0, 5'd0, 1'b1, MPP_M | 32'h88));
        steps.push_back(csr_step(CSRRW, CSR_MTVEC, TVEC | 32'd1, 5'd0, 1'b0, 32'd0));
        steps.push_back(csr_step(CSRRW, CSR_MIE, 32'h808, 5'd0, 1'b0, 32'd0)); // meie, msie
        steps.push_back(event_step(EXC_NONE, 1'b1, 1'b1, 1'b0, 32'd0, 1'b0)); // mip lags
        steps.push_back(event_step(EXC_NONE, 1'b1, 1'b1, 1'b1,
                                   TVEC + 32'(CAUSE_EXT_IRQ) * 32'd4, 1'b0));
        steps.push_back(csr_step(CSRRS, CSR_MCAUSE, 32'd0, 5'd0, 1'b1,
                                 {1'b1, 27'd0, CAUSE_EXT_IRQ}));
        steps.push_back(csr_step(CSRRW, CSR_MIE, 32'h80, 5'd0, 1'b0, 32'd0)); // timer only
        steps.push_back(csr_step(CSRRSI, CSR_MSTATUS, 32'd0, 5'd8, 1'b1, MPP_M | 32'h80));

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[i]) begin
            @(posedge clk);
            drive_step(steps[i]);
            @(negedge clk);
            if (i > 0)
                check_step(i - 1, steps[i - 1]); // outputs of the step taken at this edge
        end
        @(posedge clk);
        drive_step(idle);
        @(negedge clk);
        check_step(steps.size() - 1, steps[steps.size() - 1]);

        @(posedge clk);
        mtime_wr     <= 1'b1;
        mtime_din    <= 64'd5;
        mtimecmp_wr  <= 1'b1;
        mtimecmp_din <= 64'd7;
        @(posedge clk);
        mtime_wr    <= 1'b0;
        mtimecmp_wr <= 1'b0;
        seen = 1'b0;
        for (cnt = 0; cnt < TIMEOUT && !seen; cnt++) begin
            @(negedge clk);
            seen = go_to_trap;
        end
        if (!seen) begin
            $display("no timer interrupt trap within %0d cycles of the mtime write", TIMEOUT);
            $display("Simulation failed");
            $fatal(1, "timer trap timeout");
        end
        assert (trap_address == TVEC + 32'(CAUSE_TIMER_IRQ) * 32'd4) else
            stop_on_error($sformatf("timer trap address %h", trap_address));
        csr_read(CSR_MCAUSE, rd_a);
        assert (rd_a == {1'b1, 27'd0, CAUSE_TIMER_IRQ}) else
            stop_on_error($sformatf("timer trap mcause %h", rd_a));
        csr_read(CSR_TIME, rd_a);
        assert (rd_a >= 32'd7) else
            stop_on_error($sformatf("time %0d is below mtimecmp", rd_a));

        n = $urandom_range(20, 3);
        csr_read(CSR_MCYCLE, rd_a);
        repeat (n - 2) @(posedge clk); // second access lands n clocks after the first
        csr_read(CSR_MCYCLE, rd_b);
        // the first access rewrites mcycle with its own value, so that edge adds nothing
        assert (rd_b - rd_a == 32'(n - 1)) else
            stop_on_error($sformatf("mcycle %0d then %0d over %0d clocks", rd_a, rd_b, n));

        if (csr_unit_inst.checker_inst.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "bound assertions failed");
        end
    end
endmodule
